//--- src/audio_upsampler_config.svh
`ifndef AUDIO_UPSAMPLER_CONFIG_SVH
`define AUDIO_UPSAMPLER_CONFIG_SVH

// channel count and index width
`define AU_NUM_CH 4
`define AU_CH_W 2

`define AU_SAMPLE_W 24

// per-channel sample buffer
`define AU_FIFO_DEPTH 8

`endif

//--- src/audio_upsampler_pkg.sv
`default_nettype none

`include "audio_upsampler_config.svh"

package audio_upsampler_pkg;

    typedef logic signed [`AU_SAMPLE_W-1:0] sample_t;

    typedef enum logic {
        RATE_96  = 1'b0,
        RATE_192 = 1'b1
    } rate_e;

    // apb register offsets
    typedef enum logic [3:0] {
        REG_RATE_MAP   = 4'h0,
        REG_SAMPLE_CNT = 4'h4
    } reg_addr_e;

    typedef enum logic [1:0] {
        S_FETCH,
        S_EMIT_MID,
        S_EMIT_CUR
    } interp_state_e;

endpackage

`default_nettype wire

//--- src/sample_in_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "audio_upsampler_config.svh"

interface sample_in_if;
    import audio_upsampler_pkg::*;

    logic    valid;
    logic    ready;
    sample_t data;
    // rate tag captured when the router accepted the sample
    rate_e   rate;

    modport router (
        output valid,
        output data,
        output rate,
        input  ready
    );

    modport chan (
        input  valid,
        input  data,
        input  rate,
        output ready
    );

endinterface

`default_nettype wire

//--- src/apb_rate_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "audio_upsampler_config.svh"

module apb_rate_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [3:0]            paddr_i,
    input  logic [31:0]           pwdata_i,
    output logic [31:0]           prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,
    input  logic                  out_fire_i,
    output logic [`AU_NUM_CH-1:0] rate_map_o
);
    import audio_upsampler_pkg::*;

    logic [`AU_NUM_CH-1:0] rate_map_q;
    logic [15:0]           sample_cnt_q;
    logic                  access;
    logic                  bad_addr;
    logic                  ro_write;

    // no wait states
    assign pready_o = 1'b1;
    assign access   = psel_i && penable_i;

    always_comb begin
        prdata_o = '0;
        bad_addr = 1'b0;
        case (paddr_i)
            REG_RATE_MAP:   prdata_o[`AU_NUM_CH-1:0] = rate_map_q;
            REG_SAMPLE_CNT: prdata_o[15:0] = sample_cnt_q;
            default:        bad_addr = 1'b1;
        endcase
    end

    // counter register is read only
    assign ro_write  = pwrite_i && (paddr_i == REG_SAMPLE_CNT);
    assign pslverr_o = access && (bad_addr || ro_write);

    // all channels start at 96 kHz
    always_ff @(posedge clk) begin
        if (rst) begin
            rate_map_q <= '0;
        end else if (access && pwrite_i && (paddr_i == REG_RATE_MAP)) begin
            rate_map_q <= pwdata_i[`AU_NUM_CH-1:0];
        end
    end

    // wraps at 16 bits
    always_ff @(posedge clk) begin
        if (rst) begin
            sample_cnt_q <= '0;
        end else if (out_fire_i) begin
            sample_cnt_q <= sample_cnt_q + 16'd1;
        end
    end

    assign rate_map_o = rate_map_q;

endmodule

`default_nettype wire

//--- src/input_router.sv
`timescale 1ns/1ns
`default_nettype none

`include "audio_upsampler_config.svh"

module input_router (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         in_valid_i,
    input  logic [`AU_CH_W-1:0]          in_ch_i,
    input  audio_upsampler_pkg::sample_t in_data_i,
    output logic                         in_ready_o,
    input  logic [`AU_NUM_CH-1:0]        rate_map_i,
    sample_in_if.router                  ch_if [`AU_NUM_CH]
);
    import audio_upsampler_pkg::*;

    logic                  hold_vld_q;
    logic [`AU_CH_W-1:0]   hold_ch_q;
    sample_t               hold_data_q;
    rate_e                 hold_rate_q;
    logic                  rdy_en_q;
    logic [`AU_NUM_CH-1:0] ch_ready;
    logic                  take;
    logic                  accept;

    for (genvar g = 0; g < `AU_NUM_CH; g++) begin : g_ch
        assign ch_if[g].valid = hold_vld_q && (hold_ch_q == g);
        assign ch_if[g].data  = hold_data_q;
        assign ch_if[g].rate  = hold_rate_q;
        assign ch_ready[g]    = ch_if[g].ready;
    end

    assign take       = hold_vld_q && ch_ready[hold_ch_q];
    assign in_ready_o = rdy_en_q && (!hold_vld_q || take);
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            hold_vld_q <= 1'b0;
            rdy_en_q   <= 1'b0;
        end else begin
            // input held off for one cycle out of reset
            rdy_en_q <= 1'b1;
            if (accept) begin
                hold_vld_q <= 1'b1;
            end else if (take) begin
                hold_vld_q <= 1'b0;
            end
        end
    end

    // rate tag uses the map as it stands at the accept edge
    always_ff @(posedge clk) begin
        if (accept) begin
            hold_ch_q   <= in_ch_i;
            hold_data_q <= in_data_i;
            hold_rate_q <= rate_e'(rate_map_i[in_ch_i]);
        end
    end

endmodule

`default_nettype wire

//--- src/channel_interpolator.sv
`timescale 1ns/1ns
`default_nettype none

`include "audio_upsampler_config.svh"

module channel_interpolator (
    input  logic                         clk,
    input  logic                         rst,
    sample_in_if.chan                    in_if,
    output logic                         out_valid_o,
    output audio_upsampler_pkg::sample_t out_data_o,
    input  logic                         out_ready_i
);
    import audio_upsampler_pkg::*;

    localparam int PTR_W = $clog2(`AU_FIFO_DEPTH);

    sample_t           mem_data [`AU_FIFO_DEPTH];
    rate_e             mem_rate [`AU_FIFO_DEPTH];
    logic [PTR_W:0]    wr_ptr_q;
    logic [PTR_W:0]    rd_ptr_q;
    logic [PTR_W-1:0]  wr_idx;
    logic [PTR_W-1:0]  rd_idx;
    logic              full;
    logic              empty;
    logic              push;
    logic              pop;

    interp_state_e     state_q;
    sample_t           cur_q;
    sample_t           prev_q;
    logic signed [`AU_SAMPLE_W:0] mid_sum;
    sample_t           mid_data;

    assign wr_idx = wr_ptr_q[PTR_W-1:0];
    assign rd_idx = rd_ptr_q[PTR_W-1:0];
    assign empty  = (wr_ptr_q == rd_ptr_q);
    assign full   = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) && (wr_idx == rd_idx);

    assign in_if.ready = !full;
    assign push = in_if.valid && !full;
    assign pop  = (state_q == S_FETCH) && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_data[wr_idx] <= in_if.data;
            mem_rate[wr_idx] <= in_if.rate;
        end
    end

    // floor((prev + cur) / 2), sign extended to avoid overflow
    assign mid_sum  = {prev_q[`AU_SAMPLE_W-1], prev_q} + {cur_q[`AU_SAMPLE_W-1], cur_q};
    assign mid_data = mid_sum[`AU_SAMPLE_W:1];

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_FETCH;
            prev_q  <= '0;
        end else begin
            case (state_q)
                S_FETCH: begin
                    if (!empty) begin
                        state_q <= (mem_rate[rd_idx] == RATE_96) ? S_EMIT_MID : S_EMIT_CUR;
                    end
                end
                S_EMIT_MID: begin
                    if (out_ready_i) begin
                        state_q <= S_EMIT_CUR;
                    end
                end
                S_EMIT_CUR: begin
                    if (out_ready_i) begin
                        state_q <= S_FETCH;
                        // history for the next midpoint
                        prev_q  <= cur_q;
                    end
                end
                default: state_q <= S_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cur_q <= mem_data[rd_idx];
        end
    end

    assign out_valid_o = (state_q != S_FETCH);
    assign out_data_o  = (state_q == S_EMIT_MID) ? mid_data : cur_q;

endmodule

`default_nettype wire

//--- src/output_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "audio_upsampler_config.svh"

module output_arbiter (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`AU_NUM_CH-1:0]        ch_valid_i,
    input  audio_upsampler_pkg::sample_t ch_data_i [`AU_NUM_CH],
    output logic [`AU_NUM_CH-1:0]        ch_ready_o,
    output logic                         out_valid_o,
    output logic [`AU_CH_W-1:0]          out_ch_o,
    output audio_upsampler_pkg::sample_t out_data_o,
    input  logic                         out_ready_i
);
    import audio_upsampler_pkg::*;

    logic                out_valid_q;
    logic [`AU_CH_W-1:0] out_ch_q;
    sample_t             out_data_q;
    logic [`AU_CH_W-1:0] last_q;
    logic                load_en;
    logic                grant_vld;
    logic [`AU_CH_W-1:0] grant_idx;

    // register empty or draining this cycle
    assign load_en = !out_valid_q || out_ready_i;

    // search starts one past the last grant
    always_comb begin
        logic [`AU_CH_W-1:0] idx;
        grant_vld = 1'b0;
        grant_idx = last_q;
        for (int i = 1; i <= `AU_NUM_CH; i++) begin
            idx = last_q + `AU_CH_W'(i);
            if (!grant_vld && ch_valid_i[idx]) begin
                grant_vld = 1'b1;
                grant_idx = idx;
            end
        end
    end

    for (genvar g = 0; g < `AU_NUM_CH; g++) begin : g_rdy
        assign ch_ready_o[g] = load_en && grant_vld && (grant_idx == g);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q <= 1'b0;
            last_q      <= `AU_CH_W'(`AU_NUM_CH - 1);
        end else if (load_en) begin
            out_valid_q <= grant_vld;
            if (grant_vld) begin
                last_q <= grant_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_en && grant_vld) begin
            out_ch_q   <= grant_idx;
            out_data_q <= ch_data_i[grant_idx];
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_ch_o    = out_ch_q;
    assign out_data_o  = out_data_q;

endmodule

`default_nettype wire

//--- src/audio_upsampler.sv
`timescale 1ns/1ns
`default_nettype none

`include "audio_upsampler_config.svh"

module audio_upsampler (
    input  logic                         clk,
    input  logic                         rst,

    // tagged sample input
    input  logic                         in_valid_i,
    input  logic [`AU_CH_W-1:0]          in_ch_i,
    input  audio_upsampler_pkg::sample_t in_data_i,
    output logic                         in_ready_o,

    // merged sample output
    output logic                         out_valid_o,
    output logic [`AU_CH_W-1:0]          out_ch_o,
    output audio_upsampler_pkg::sample_t out_data_o,
    input  logic                         out_ready_i,

    // apb
    input  logic                         psel_i,
    input  logic                         penable_i,
    input  logic                         pwrite_i,
    input  logic [3:0]                   paddr_i,
    input  logic [31:0]                  pwdata_i,
    output logic [31:0]                  prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o
);
    import audio_upsampler_pkg::*;

    logic [`AU_NUM_CH-1:0] rate_map;
    logic [`AU_NUM_CH-1:0] ch_valid;
    logic [`AU_NUM_CH-1:0] ch_ready;
    sample_t               ch_data [`AU_NUM_CH];
    logic                  out_fire;

    sample_in_if ch_if [`AU_NUM_CH] ();

    assign out_fire = out_valid_o && out_ready_i;

    apb_rate_regs i_regs (
        .clk        (clk),
        .rst        (rst),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .paddr_i    (paddr_i),
        .pwdata_i   (pwdata_i),
        .prdata_o   (prdata_o),
        .pready_o   (pready_o),
        .pslverr_o  (pslverr_o),
        .out_fire_i (out_fire),
        .rate_map_o (rate_map)
    );

    input_router i_router (
        .clk        (clk),
        .rst        (rst),
        .in_valid_i (in_valid_i),
        .in_ch_i    (in_ch_i),
        .in_data_i  (in_data_i),
        .in_ready_o (in_ready_o),
        .rate_map_i (rate_map),
        .ch_if      (ch_if)
    );

    for (genvar g = 0; g < `AU_NUM_CH; g++) begin : g_chan
        channel_interpolator i_interp (
            .clk         (clk),
            .rst         (rst),
            .in_if       (ch_if[g]),
            .out_valid_o (ch_valid[g]),
            .out_data_o  (ch_data[g]),
            .out_ready_i (ch_ready[g])
        );
    end

    output_arbiter i_arb (
        .clk         (clk),
        .rst         (rst),
        .ch_valid_i  (ch_valid),
        .ch_data_i   (ch_data),
        .ch_ready_o  (ch_ready),
        .out_valid_o (out_valid_o),
        .out_ch_o    (out_ch_o),
        .out_data_o  (out_data_o),
        .out_ready_i (out_ready_i)
    );

endmodule

`default_nettype wire

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (3) @(posedge clk_o);
        #1;
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

//--- verif/audio_upsampler_assert.sv
`timescale 1ns/1ns
`default_nettype none

`include "audio_upsampler_config.svh"

module audio_upsampler_assert (
    input logic                         clk,
    input logic                         rst,
    input logic                         in_ready_o,
    input logic                         out_valid_o,
    input logic [`AU_CH_W-1:0]          out_ch_o,
    input audio_upsampler_pkg::sample_t out_data_o,
    input logic                         out_ready_i,
    input logic                         pready_o
);

    // failed properties so far
    int n_fail = 0;

    // stalled output keeps its payload
    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o) && $stable(out_ch_o))
        else begin
            n_fail++;
            $error("output payload changed while stalled");
        end

    a_ready_after_rst: assert property (@(posedge clk) $fell(rst) |-> !in_ready_o)
        else begin
            n_fail++;
            $error("in_ready_o high on first cycle after reset");
        end

    a_valid_after_rst: assert property (@(posedge clk) $fell(rst) |-> !out_valid_o)
        else begin
            n_fail++;
            $error("out_valid_o high right after reset");
        end

    a_pready: assert property (@(posedge clk) disable iff (rst) pready_o)
        else begin
            n_fail++;
            $error("pready_o dropped");
        end

endmodule

`default_nettype wire

//--- verif/tb_audio_upsampler.sv
`timescale 1ns/1ns
`default_nettype none

`include "audio_upsampler_config.svh"

module tb_audio_upsampler;
    import audio_upsampler_pkg::*;

    localparam int N_PHASE2 = 16;
    localparam int N_PHASE3 = 24;
    localparam int N_PHASE4 = 64;
    localparam int TIMEOUT_CYCLES = 20 * (N_PHASE2 + N_PHASE3 + N_PHASE4) + 200;

    logic clk;
    logic rst;
    logic in_valid_i;
    logic [`AU_CH_W-1:0] in_ch_i;
    sample_t in_data_i;
    logic in_ready_o;
    logic out_valid_o;
    logic [`AU_CH_W-1:0] out_ch_o;
    sample_t out_data_o;
    logic out_ready_i;
    logic psel_i;
    logic penable_i;
    logic pwrite_i;
    logic [3:0] paddr_i;
    logic [31:0] pwdata_i;
    logic [31:0] prdata_o;
    logic pready_o;
    logic pslverr_o;

    sample_t exp_q [`AU_NUM_CH][$];
    sample_t prev_mirror [`AU_NUM_CH];
    logic [`AU_NUM_CH-1:0] rate_mirror;
    logic [31:0] lfsr_q;
    logic stall_en;
    int out_cnt;
    int cycle_cnt;
    int n_errors;

    tb_clk_gen i_clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    audio_upsampler i_dut (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (in_valid_i),
        .in_ch_i     (in_ch_i),
        .in_data_i   (in_data_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .out_ch_o    (out_ch_o),
        .out_data_o  (out_data_o),
        .out_ready_i (out_ready_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o)
    );

    bind audio_upsampler audio_upsampler_assert i_assert (.*);

    task automatic fail_run(input string why);
        n_errors++;
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t ns: %s, got %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    // 96 kHz gives floor of the midpoint then the sample, 192 kHz the sample alone
    function automatic void ref_upsample(input rate_e rate, input sample_t prev,
                                         input sample_t cur, output int n_out,
                                         output sample_t out0, output sample_t out1);
        int sum;
        int mid;
        sum = int'(prev) + int'(cur);
        mid = (sum < 0 && (sum % 2) != 0) ? sum / 2 - 1 : sum / 2;
        out1 = cur;
        if (rate == RATE_96) begin
            n_out = 2;
            out0 = sample_t'(mid);
        end else begin
            n_out = 1;
            out0 = cur;
        end
    endfunction

    task automatic step_cycle();
        logic [31:0] v;
        @(posedge clk);
        #1;
        if (stall_en) begin
            draw_bits(1, v);
            out_ready_i = v[0];
        end else begin
            out_ready_i = 1'b1;
        end
    endtask

    task automatic send_sample(input logic [`AU_CH_W-1:0] ch, input sample_t data);
        logic accepted;
        int n_out;
        sample_t o0;
        sample_t o1;
        in_valid_i = 1'b1;
        in_ch_i = ch;
        in_data_i = data;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = in_ready_o;
            step_cycle();
        end
        // tag with the rate map as it stood at the accept edge
        ref_upsample(rate_e'(rate_mirror[ch]), prev_mirror[ch], data, n_out, o0, o1);
        exp_q[ch].push_back(o0);
        if (n_out == 2) begin
            exp_q[ch].push_back(o1);
        end
        prev_mirror[ch] = data;
        in_valid_i = 1'b0;
    endtask

    task automatic send_random(input int n);
        logic [31:0] ch;
        logic [31:0] data;
        for (int i = 0; i < n; i++) begin
            draw_bits(`AU_CH_W, ch);
            draw_bits(`AU_SAMPLE_W, data);
            send_sample(ch[`AU_CH_W-1:0], sample_t'(data[`AU_SAMPLE_W-1:0]));
        end
    endtask

    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        psel_i = 1'b1;
        penable_i = 1'b0;
        pwrite_i = wr;
        paddr_i = addr;
        pwdata_i = wdata;
        step_cycle();
        penable_i = 1'b1;
        @(negedge clk);
        rdata = prdata_o;
        err = pslverr_o;
        step_cycle();
        psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
        if (wr && addr == REG_RATE_MAP) begin
            rate_mirror = wdata[`AU_NUM_CH-1:0];
        end
    endtask

    task automatic wait_drain();
        int pending;
        pending = 1;
        while (pending != 0) begin
            step_cycle();
            pending = 0;
            for (int c = 0; c < `AU_NUM_CH; c++) begin
                pending += exp_q[c].size();
            end
        end
    endtask

    // compare on every output transfer
    always @(posedge clk) begin
        sample_t exp_s;
        if (!rst && out_valid_o && out_ready_i) begin
            if (exp_q[out_ch_o].size() == 0) begin
                fail_run($sformatf("output on channel %0d with no sample expected", out_ch_o));
            end else begin
                exp_s = exp_q[out_ch_o].pop_front();
                check_equal(out_data_o, exp_s, $sformatf("channel %0d output", out_ch_o));
                out_cnt++;
            end
        end
    end

    // a failed bound property also ends the run
    always @(posedge clk) begin
        if (i_dut.i_assert.n_fail != 0) begin
            fail_run("bound assertion failed");
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout after %0d cycles, outputs still missing", cycle_cnt));
        end
    end

    initial begin
        logic [31:0] rdata;
        logic err;
        in_valid_i = 1'b0;
        in_ch_i = '0;
        in_data_i = '0;
        out_ready_i = 1'b1;
        psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
        paddr_i = '0;
        pwdata_i = '0;
        lfsr_q = 32'he011;
        stall_en = 1'b0;
        rate_mirror = '0;
        out_cnt = 0;
        cycle_cnt = 0;
        n_errors = 0;
        for (int c = 0; c < `AU_NUM_CH; c++) begin
            prev_mirror[c] = '0;
        end
        @(negedge rst);
        step_cycle();

        apb_access(1'b0, REG_RATE_MAP, '0, rdata, err);
        check_equal(rdata, 32'h0, "rate map after reset");
        check_equal(err, 1'b0, "pslverr on rate map read");
        apb_access(1'b0, REG_SAMPLE_CNT, '0, rdata, err);
        check_equal(rdata, 32'h0, "sample count after reset");
        check_equal(out_valid_o, 1'b0, "out_valid_o after reset");

        // all channels interpolating, first midpoint against zero
        send_random(N_PHASE2);

        // earlier samples may still be queued with the old rate
        apb_access(1'b1, REG_RATE_MAP, 32'h5, rdata, err);
        check_equal(err, 1'b0, "pslverr on rate map write");
        apb_access(1'b0, REG_RATE_MAP, '0, rdata, err);
        check_equal(rdata, 32'h5, "rate map readback");
        send_random(N_PHASE3);

        stall_en = 1'b1;
        send_random(N_PHASE4);
        stall_en = 1'b0;
        wait_drain();
        repeat (4) step_cycle();
        check_equal(out_valid_o, 1'b0, "out_valid_o after drain");

        apb_access(1'b0, REG_SAMPLE_CNT, '0, rdata, err);
        check_equal(rdata, {16'h0, out_cnt[15:0]}, "sample count");

        apb_access(1'b1, REG_SAMPLE_CNT, 32'h1234, rdata, err);
        check_equal(err, 1'b1, "pslverr on counter write");
        apb_access(1'b0, 4'h8, '0, rdata, err);
        check_equal(err, 1'b1, "pslverr on unmapped read");
        apb_access(1'b0, REG_RATE_MAP, '0, rdata, err);
        check_equal(rdata, 32'h5, "rate map after bad accesses");
        apb_access(1'b0, REG_SAMPLE_CNT, '0, rdata, err);
        check_equal(rdata, {16'h0, out_cnt[15:0]}, "sample count after bad write");

        if (n_errors == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- audio_upsampler.f
+incdir+src
src/audio_upsampler_pkg.sv
src/sample_in_if.sv
src/apb_rate_regs.sv
src/input_router.sv
src/channel_interpolator.sv
src/output_arbiter.sv
src/audio_upsampler.sv
verif/tb_clk_gen.sv
verif/audio_upsampler_assert.sv
verif/tb_audio_upsampler.sv

//--- Bender.yml
package:
  name: audio_upsampler

sources:
  - include_dirs:
      - src
    files:
      - src/audio_upsampler_pkg.sv
      - src/sample_in_if.sv
      - src/apb_rate_regs.sv
      - src/input_router.sv
      - src/channel_interpolator.sv
      - src/output_arbiter.sv
      - src/audio_upsampler.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/tb_clk_gen.sv
      - verif/audio_upsampler_assert.sv
      - verif/tb_audio_upsampler.sv
